/* hdl/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    typedef enum logic [3:0] {
        ALU_OP_ADD,
        ALU_OP_SUB,
        ALU_OP_AND,
        ALU_OP_OR,
        ALU_OP_XOR,
        ALU_OP_SLL,
        ALU_OP_SRL,
        ALU_OP_SRA,
        ALU_OP_SLT,
        ALU_OP_SLTU,
        ALU_OP_NONE
    } alu_op_e;

    // flag word layout {neg, zero, cout, ov}
    localparam int unsigned ALU_FLAG_NEG  = 3;
    localparam int unsigned ALU_FLAG_ZERO = 2;
    localparam int unsigned ALU_FLAG_COUT = 1;
    localparam int unsigned ALU_FLAG_OV   = 0;

endpackage

`default_nettype wire

/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam logic [6:0] OP_R_TYPE   = 7'b0110011;
    localparam logic [6:0] OP_I_TYPE   = 7'b0010011;
    localparam logic [6:0] OP_I_TYPE_L = 7'b0000011; // loads
    localparam logic [6:0] OP_S_TYPE   = 7'b0100011;
    localparam logic [6:0] OP_B_TYPE   = 7'b1100011;
    localparam logic [6:0] OP_JALR     = 7'b1100111;
    localparam logic [6:0] OP_J_TYPE   = 7'b1101111; // jal

    localparam logic [31:0] IO_ADDR   = 32'h0000_0100;
    localparam int          MEM_WORDS = 256;

    typedef enum logic [2:0] {
        ALU_SRC_REG_1,
        ALU_SRC_REG_2,
        ALU_SRC_PC,
        ALU_SRC_EXT_IMM,
        ALU_SRC_4,
        ALU_SRC_NONE
    } alu_src_e;

    typedef enum logic [1:0] {RES_SRC_ALU_OUT, RES_SRC_MEM, RES_SRC_NONE} res_src_e;

    typedef enum logic [2:0] {
        IMM_SRC_NONE,
        IMM_SRC_ITYPE,
        IMM_SRC_ITYPE2, // shift amount
        IMM_SRC_STYPE,
        IMM_SRC_BTYPE,
        IMM_SRC_JTYPE
    } imm_src_e;

    typedef enum logic [2:0] {
        MEM_DT_NONE,
        MEM_DT_BYTE,
        MEM_DT_HALF,
        MEM_DT_WORD,
        MEM_DT_UBYTE,
        MEM_DT_UHALF
    } mem_dt_e;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] op;
        } r;
        struct packed {
            logic [11:0] imm_hi;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm_lo; // rd slot on I-type
            logic [6:0]  op;
        } i;
    } instr_u;

endpackage

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import alu_pkg::*; (
    input  wire [31:0]   a,
    input  wire [31:0]   b,
    input  wire alu_op_e op,
    output logic [31:0]  y,
    output logic [3:0]   flags
);
    logic        sub;
    logic [31:0] b_eff;
    logic [32:0] sum;
    logic        ov;

    assign sub   = (op == ALU_OP_SUB) || (op == ALU_OP_SLT) || (op == ALU_OP_SLTU);
    assign b_eff = sub ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {32'b0, sub}; // a + ~b + 1 on compare
    assign ov    = (a[31] == b_eff[31]) && (sum[31] != a[31]);

    always_comb begin
        case (op)
        ALU_OP_ADD, ALU_OP_SUB: y = sum[31:0];
        ALU_OP_AND:  y = a & b;
        ALU_OP_OR:   y = a | b;
        ALU_OP_XOR:  y = a ^ b;
        ALU_OP_SLL:  y = a << b[4:0];
        ALU_OP_SRL:  y = a >> b[4:0];
        ALU_OP_SRA:  y = $signed(a) >>> b[4:0];
        ALU_OP_SLT:  y = {31'b0, sum[31] ^ ov};
        ALU_OP_SLTU: y = {31'b0, ~sum[32]};   // borrow
        default:     y = '0;
        endcase
    end

    assign flags[ALU_FLAG_NEG]  = y[31];
    assign flags[ALU_FLAG_ZERO] = (y == 32'd0);
    assign flags[ALU_FLAG_COUT] = sum[32];
    assign flags[ALU_FLAG_OV]   = ov;

endmodule

`default_nettype wire

/* hdl/alu_dec.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_dec import alu_pkg::*, rv_pkg::*; (
    input  wire [6:0] op,
    input  wire [2:0] funct3,
    input  wire [6:0] funct7,
    output alu_op_e   alu_op
);
    logic is_r;
    logic is_i;

    assign is_r = (op == OP_R_TYPE);
    assign is_i = (op == OP_I_TYPE);

    always_comb begin
        alu_op = ALU_OP_NONE;
        if (op == OP_B_TYPE) begin
            alu_op = ALU_OP_SUB; // compare
        end else if (op == OP_I_TYPE_L || op == OP_S_TYPE || op == OP_JALR || op == OP_J_TYPE) begin
            alu_op = ALU_OP_ADD; // address or target
        end else if (is_r || is_i) begin
            case (funct3)
            3'b000:  alu_op = (is_r && funct7[5]) ? ALU_OP_SUB : ALU_OP_ADD;
            3'b001:  alu_op = ALU_OP_SLL;
            3'b010:  alu_op = ALU_OP_SLT;
            3'b011:  alu_op = ALU_OP_SLTU;
            3'b100:  alu_op = ALU_OP_XOR;
            3'b101:  alu_op = funct7[5] ? ALU_OP_SRA : ALU_OP_SRL; // srai keeps bit 30
            3'b110:  alu_op = ALU_OP_OR;
            default: alu_op = ALU_OP_AND;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/controller_multicycle.sv */
`timescale 1ns/1ps
`default_nettype none

module controller_multicycle import alu_pkg::*, rv_pkg::*; (
    input  wire instr_u instr,
    input  wire [3:0]   alu_flags,
    output logic        rf_we,
    output logic        m_we,
    output alu_src_e    alu_src_a,
    output alu_src_e    alu_src_b,
    output res_src_e    res_src,
    output imm_src_e    imm_src,
    output logic        rf_wd_src,
    output alu_op_e     alu_ctrl,
    output mem_dt_e     dt,
    output logic        en_ir,
    output logic        en_npc_r,
    output logic        m_addr_src,
    output logic        trap,
    input  wire         clk,
    input  wire         rst
);
    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        MEM_ADDR,
        MEM_READ,
        MEM_WRITE,
        MEM_W_RF,
        EXEC_R,
        ALU_W_RF,
        BRANCH,
        EXEC_I,
        ALU_W_PCN,
        ERROR
    } state_e;

    state_e     cs;
    state_e     ns;
    logic [6:0] op;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       is_jump;
    logic       br_take;
    logic       lt_signed;
    imm_src_e   mem_imm;
    imm_src_e   exec_imm;
    mem_dt_e    mem_dt;
    alu_op_e    dec_op;

    assign op        = instr.r.op;
    assign funct7    = instr.r.funct7;
    assign funct3    = instr.r.funct3;
    assign is_jump   = (op == OP_JALR) || (op == OP_J_TYPE);
    assign rf_wd_src = is_jump; // link value
    assign trap      = (cs == ERROR);

    always_comb begin
        case (cs)
        FETCH: ns = DECODE;
        DECODE: begin
            case (op)
            OP_R_TYPE:                     ns = EXEC_R;
            OP_I_TYPE, OP_JALR, OP_J_TYPE: ns = EXEC_I;
            OP_I_TYPE_L, OP_S_TYPE:        ns = MEM_ADDR;
            OP_B_TYPE:                     ns = BRANCH;
            default:                       ns = ERROR;
            endcase
        end
        MEM_ADDR: ns = (op == OP_I_TYPE_L) ? MEM_READ : MEM_WRITE;
        MEM_READ: ns = MEM_W_RF;
        EXEC_R:   ns = ALU_W_RF;
        EXEC_I:   ns = is_jump ? ALU_W_PCN : ALU_W_RF;
        ERROR:    ns = ERROR;              // sticky
        default:  ns = FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            cs <= FETCH;
        else
            cs <= ns;
    end

    assign lt_signed = alu_flags[ALU_FLAG_NEG] ^ alu_flags[ALU_FLAG_OV];

    always_comb begin
        case (funct3)
        3'b000:  br_take = alu_flags[ALU_FLAG_ZERO];  // beq
        3'b001:  br_take = ~alu_flags[ALU_FLAG_ZERO]; // bne
        3'b100:  br_take = lt_signed;
        3'b101:  br_take = ~lt_signed;
        3'b110:  br_take = ~alu_flags[ALU_FLAG_COUT]; // bltu
        3'b111:  br_take = alu_flags[ALU_FLAG_COUT];
        default: br_take = 1'b0;
        endcase
    end

    always_comb begin
        case (funct3)
        3'b000:  mem_dt = MEM_DT_BYTE;
        3'b001:  mem_dt = MEM_DT_HALF;
        3'b010:  mem_dt = MEM_DT_WORD;
        3'b100:  mem_dt = MEM_DT_UBYTE;
        3'b101:  mem_dt = MEM_DT_UHALF;
        default: mem_dt = MEM_DT_NONE;
        endcase
    end

    assign mem_imm = (op == OP_I_TYPE_L) ? IMM_SRC_ITYPE : IMM_SRC_STYPE;

    always_comb begin
        if (op == OP_J_TYPE)
            exec_imm = IMM_SRC_JTYPE;
        else if (op == OP_I_TYPE && funct3[1:0] == 2'b01)
            exec_imm = IMM_SRC_ITYPE2; // slli, srli, srai
        else
            exec_imm = IMM_SRC_ITYPE;
    end

    alu_dec alu_dec_i (
        .op     (op),
        .funct3 (funct3),
        .funct7 (funct7),
        .alu_op (dec_op)
    );

    always_comb begin
        rf_we      = 1'b0;
        m_we       = 1'b0;
        alu_src_a  = ALU_SRC_NONE;
        alu_src_b  = ALU_SRC_NONE;
        res_src    = RES_SRC_NONE;
        imm_src    = IMM_SRC_NONE;
        alu_ctrl   = ALU_OP_ADD;
        dt         = MEM_DT_NONE;
        en_ir      = 1'b0;
        en_npc_r   = 1'b0;
        m_addr_src = 1'b0;
        case (cs)
        FETCH: begin
            en_ir = 1'b1;
            dt    = MEM_DT_WORD;
        end
        DECODE: begin
            // branch target from the old PC for BRANCH
            alu_src_a = ALU_SRC_PC;
            alu_src_b = ALU_SRC_EXT_IMM;
            imm_src   = IMM_SRC_BTYPE;
        end
        MEM_ADDR, MEM_READ, MEM_WRITE, MEM_W_RF: begin
            alu_src_a  = ALU_SRC_REG_1;
            alu_src_b  = ALU_SRC_EXT_IMM; // address held in ALU-out
            imm_src    = mem_imm;
            dt         = mem_dt;
            m_addr_src = (cs != MEM_ADDR);
            m_we       = (cs == MEM_WRITE);
            rf_we      = (cs == MEM_W_RF);
            res_src    = (cs == MEM_W_RF) ? RES_SRC_MEM : RES_SRC_NONE;
        end
        EXEC_R: begin
            alu_src_a = ALU_SRC_REG_1;
            alu_src_b = ALU_SRC_REG_2;
            alu_ctrl  = dec_op;
        end
        EXEC_I: begin
            alu_src_a = (op == OP_J_TYPE) ? ALU_SRC_PC : ALU_SRC_REG_1;
            alu_src_b = ALU_SRC_EXT_IMM;
            imm_src   = exec_imm;
            alu_ctrl  = dec_op;
        end
        ALU_W_RF: begin
            rf_we    = 1'b1;
            res_src  = RES_SRC_ALU_OUT;
            alu_ctrl = ALU_OP_NONE;
        end
        ALU_W_PCN: begin
            rf_we     = 1'b1;
            res_src   = RES_SRC_ALU_OUT;
            alu_src_a = ALU_SRC_PC;   // old pc + 4
            alu_src_b = ALU_SRC_4;
            en_npc_r  = 1'b1;
        end
        BRANCH: begin
            alu_src_a = ALU_SRC_REG_1;
            alu_src_b = ALU_SRC_REG_2;
            alu_ctrl  = dec_op;
            en_npc_r  = br_take;
        end
        default: alu_ctrl = ALU_OP_NONE;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath import alu_pkg::*, rv_pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire           rf_we,
    input  wire alu_src_e alu_src_a,
    input  wire alu_src_e alu_src_b,
    input  wire res_src_e res_src,
    input  wire imm_src_e imm_src,
    input  wire           rf_wd_src,
    input  wire alu_op_e  alu_ctrl,
    input  wire           en_ir,
    input  wire           en_npc_r,
    input  wire           m_addr_src,
    input  wire [31:0]    m_rdata,
    output instr_u        instr,
    output logic [3:0]    alu_flags,
    output logic [31:0]   m_addr,
    output logic [31:0]   m_wdata
);
    logic [31:0] pc;
    logic [31:0] old_pc;
    logic [31:0] rf [32];
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] a_r;
    logic [31:0] b_r;
    logic [31:0] imm_ext;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] alu_y;
    logic [31:0] alu_out_r;
    logic [31:0] rf_wd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pc <= '0;
        else if (en_ir)
            pc <= pc + 32'd4;
        else if (en_npc_r)
            pc <= {alu_out_r[31:1], 1'b0}; // jalr drops bit 0
    end

    always_ff @(posedge clk) begin
        if (en_ir) begin
            old_pc <= pc;
            instr  <= m_rdata;
        end
    end

    assign rd1 = (instr.r.rs1 == 5'd0) ? 32'd0 : rf[instr.r.rs1];
    assign rd2 = (instr.r.rs2 == 5'd0) ? 32'd0 : rf[instr.r.rs2];

    always_ff @(posedge clk) begin
        if (rf_we && instr.r.rd != 5'd0)
            rf[instr.r.rd] <= rf_wd;
        a_r       <= rd1;
        b_r       <= rd2;
        alu_out_r <= alu_y;
    end

    always_comb begin
        case (imm_src)
        IMM_SRC_ITYPE:  imm_ext = {{20{instr.i.imm_hi[11]}}, instr.i.imm_hi};
        IMM_SRC_ITYPE2: imm_ext = {27'd0, instr.i.imm_hi[4:0]};
        IMM_SRC_STYPE:  imm_ext = {{20{instr.i.imm_hi[11]}}, instr.i.imm_hi[11:5], instr.i.imm_lo};
        IMM_SRC_BTYPE:  imm_ext = {{20{instr.i.imm_hi[11]}}, instr.i.imm_lo[0],
                                   instr.i.imm_hi[10:5], instr.i.imm_lo[4:1], 1'b0};
        IMM_SRC_JTYPE:  imm_ext = {{12{instr.i.imm_hi[11]}}, instr.i.rs1, instr.i.funct3,
                                   instr.i.imm_hi[0], instr.i.imm_hi[10:1], 1'b0};
        default:        imm_ext = '0;
        endcase
    end

    assign src_a = (alu_src_a == ALU_SRC_REG_1) ? a_r :
                   (alu_src_a == ALU_SRC_PC)    ? old_pc : 32'd0;

    always_comb begin
        case (alu_src_b)
        ALU_SRC_REG_2:   src_b = b_r;
        ALU_SRC_EXT_IMM: src_b = imm_ext;
        ALU_SRC_4:       src_b = 32'd4;
        default:         src_b = '0;
        endcase
    end

    alu alu_i (
        .a     (src_a),
        .b     (src_b),
        .op    (alu_ctrl),
        .y     (alu_y),
        .flags (alu_flags)
    );

    assign rf_wd   = rf_wd_src ? alu_y :                         // old pc + 4
                     (res_src == RES_SRC_MEM) ? m_rdata : alu_out_r;
    assign m_addr  = m_addr_src ? alu_out_r : pc;
    assign m_wdata = b_r;

endmodule

`default_nettype wire

/* hdl/rv_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_mem import rv_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire [31:0]   m_addr,
    input  wire [31:0]   m_wdata,
    input  wire          m_we,
    input  wire mem_dt_e dt,
    output logic [31:0]  m_rdata,
    input  wire          load_we,
    input  wire [7:0]    load_addr,
    input  wire [31:0]   load_data,
    output logic [31:0]  io_data,
    output logic         io_strobe
);
    logic [31:0]                  mem [MEM_WORDS];
    logic [$clog2(MEM_WORDS)-1:0] word_idx;
    logic [31:0]                  rd_word;
    logic [7:0]                   rd_byte;
    logic [15:0]                  rd_half;
    logic                         io_hit;

    assign word_idx = m_addr[$clog2(MEM_WORDS)+1:2];
    assign rd_word  = mem[word_idx];
    assign rd_byte  = rd_word[8*m_addr[1:0] +: 8];
    assign rd_half  = rd_word[16*m_addr[1] +: 16];
    assign io_hit   = m_we && (m_addr == IO_ADDR);

    always_comb begin
        case (dt)
        MEM_DT_BYTE:  m_rdata = {{24{rd_byte[7]}}, rd_byte};
        MEM_DT_UBYTE: m_rdata = {24'd0, rd_byte};
        MEM_DT_HALF:  m_rdata = {{16{rd_half[15]}}, rd_half};
        MEM_DT_UHALF: m_rdata = {16'd0, rd_half};
        default:      m_rdata = rd_word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            if (load_we)
                mem[load_addr] <= load_data; // image load
        end else if (io_hit) begin
            io_data <= m_wdata;
        end else if (m_we) begin
            case (dt)
            MEM_DT_BYTE, MEM_DT_UBYTE: mem[word_idx][8*m_addr[1:0] +: 8] <= m_wdata[7:0];
            MEM_DT_HALF, MEM_DT_UHALF: mem[word_idx][16*m_addr[1] +: 16] <= m_wdata[15:0];
            MEM_DT_WORD:               mem[word_idx] <= m_wdata;
            default:                   ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            io_strobe <= 1'b0;
        else
            io_strobe <= io_hit;
    end

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core import alu_pkg::*, rv_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         load_we,
    input  wire [7:0]   load_addr,
    input  wire [31:0]  load_data,
    output logic [31:0] io_data,
    output logic        io_strobe,
    output logic        trap
);
    logic        rf_we;
    logic        m_we;
    alu_src_e    alu_src_a;
    alu_src_e    alu_src_b;
    res_src_e    res_src;
    imm_src_e    imm_src;
    logic        rf_wd_src;
    alu_op_e     alu_ctrl;
    mem_dt_e     dt;
    logic        en_ir;
    logic        en_npc_r;
    logic        m_addr_src;
    instr_u      instr;
    logic [3:0]  alu_flags;
    logic [31:0] m_addr;
    logic [31:0] m_wdata;
    logic [31:0] m_rdata;

    controller_multicycle controller_i (
        .instr      (instr),
        .alu_flags  (alu_flags),
        .rf_we      (rf_we),
        .m_we       (m_we),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .res_src    (res_src),
        .imm_src    (imm_src),
        .rf_wd_src  (rf_wd_src),
        .alu_ctrl   (alu_ctrl),
        .dt         (dt),
        .en_ir      (en_ir),
        .en_npc_r   (en_npc_r),
        .m_addr_src (m_addr_src),
        .trap       (trap),
        .clk        (clk),
        .rst        (rst)
    );

    datapath datapath_i (
        .clk        (clk),
        .rst        (rst),
        .rf_we      (rf_we),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .res_src    (res_src),
        .imm_src    (imm_src),
        .rf_wd_src  (rf_wd_src),
        .alu_ctrl   (alu_ctrl),
        .en_ir      (en_ir),
        .en_npc_r   (en_npc_r),
        .m_addr_src (m_addr_src),
        .m_rdata    (m_rdata),
        .instr      (instr),
        .alu_flags  (alu_flags),
        .m_addr     (m_addr),
        .m_wdata    (m_wdata)
    );

    rv_mem mem_i (
        .clk       (clk),
        .rst       (rst),
        .m_addr    (m_addr),
        .m_wdata   (m_wdata),
        .m_we      (m_we),
        .dt        (dt),
        .m_rdata   (m_rdata),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .io_data   (io_data),
        .io_strobe (io_strobe)
    );

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter realtime PERIOD = 8ns
) (
    output logic clk
);
    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* tests/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    localparam int RESET_CYCLES  = 16;
    localparam int SETTLE_CYCLES = 40;  // quiet window after the last io write
    localparam int WAIT_MARGIN   = 20;

    logic        clk;
    logic        rst;
    logic        load_we;
    logic [7:0]  load_addr;
    logic [31:0] load_data;
    logic [31:0] io_data;
    logic        io_strobe;
    logic        trap;

    logic [31:0] prog_words [$];
    logic [31:0] exp_vals [$];
    int          test_nwords [$];
    int          test_nexp [$];
    int          test_trap [$];
    int          errors;
    int          pass_count;
    int          fail_count;
    int          watchdog_cycles;
    logic        vectors_ready;

    tb_clock clock_i (.clk(clk));

    rv_core rv_core_i (
        .clk       (clk),
        .rst       (rst),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .io_data   (io_data),
        .io_strobe (io_strobe),
        .trap      (trap)
    );

    task automatic read_vectors();
        int          fd;
        int          code;
        int          nw;
        int          ne;
        int          tr;
        logic [31:0] word;
        logic [8*256-1:0] line;
        fd = $fopen("tests/rv_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/rv_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%d %d %d", nw, ne, tr);
            if (code == 3) begin
                test_nwords.push_back(nw);
                test_nexp.push_back(ne);
                test_trap.push_back(tr);
                for (int i = 0; i < nw; i++) begin
                    code = $fscanf(fd, "%h", word);
                    prog_words.push_back(word);
                end
                for (int i = 0; i < ne; i++) begin
                    code = $fscanf(fd, "%h", word);
                    exp_vals.push_back(word);
                end
                watchdog_cycles += ((nw > RESET_CYCLES) ? nw : RESET_CYCLES) + nw * 5
                                   + WAIT_MARGIN + SETTLE_CYCLES + 10;
            end else if (code < 0) begin
                break;
            end else begin
                code = $fgets(line, fd); // comment line
            end
        end
        $fclose(fd);
    endtask

    // image goes in while the core is held in reset
    task automatic load_image(input int base, input int nwords);
        int hold;
        hold = (nwords > RESET_CYCLES) ? nwords : RESET_CYCLES;
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < hold; i++) begin
            load_we   = (i < nwords);
            load_addr = i[7:0];
            load_data = (i < nwords) ? prog_words[base + i] : 32'd0;
            @(posedge clk);
            #1;
        end
        load_we = 1'b0;
        rst     = 1'b0;
    endtask

    task automatic run_program(input int t, input int wbase, input int ebase);
        int seen;
        int waited;
        int limit;
        int extra;
        int errs_before;
        errs_before = errors;
        seen        = 0;
        waited      = 0;
        extra       = 0;
        limit       = test_nwords[t] * 5 + WAIT_MARGIN;
        load_image(wbase, test_nwords[t]);
        while (seen < test_nexp[t] && waited < limit) begin
            @(negedge clk);
            waited++;
            if (io_strobe) begin
                assert (io_data == exp_vals[ebase + seen]) else begin
                    $display("Fail at %0t: test %0d io write %0d is %h, expected %h",
                             $time, t, seen, io_data, exp_vals[ebase + seen]);
                    errors++;
                end
                seen++;
            end
        end
        if (seen < test_nexp[t]) begin
            $display("test %0d timed out after %0d cycles, saw %0d of %0d io writes",
                     t, waited, seen, test_nexp[t]);
            errors++;
        end
        repeat (SETTLE_CYCLES) begin
            @(negedge clk);
            if (io_strobe)
                extra++;
        end
        assert (extra == 0) else begin
            $display("Fail at %0t: test %0d gave %0d io writes too many", $time, t, extra);
            errors++;
        end
        assert (trap == (test_trap[t] != 0)) else begin
            $display("Fail at %0t: test %0d trap is %b, expected %0d", $time, t, trap,
                     test_trap[t]);
            errors++;
        end
        if (errors == errs_before) begin
            pass_count++;
            $display("test %0d passed (%0d io writes)", t, seen);
        end else begin
            fail_count++;
            $display("test %0d failed", t);
        end
    endtask

    initial begin
        wait (vectors_ready);
        repeat (watchdog_cycles + 200) @(posedge clk);
        $display("watchdog expired, the run did not finish in %0d cycles", watchdog_cycles + 200);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int wbase;
        int ebase;
        rst             = 1'b1;
        load_we         = 1'b0;
        load_addr       = 8'd0;
        load_data       = 32'd0;
        errors          = 0;
        pass_count      = 0;
        fail_count      = 0;
        watchdog_cycles = 0;
        vectors_ready   = 1'b0;
        wbase           = 0;
        ebase           = 0;
        void'($urandom(41534));
        read_vectors();
        vectors_ready = 1'b1;
        if (test_nwords.size() == 0) begin
            $display("no tests found in the vectors file");
            fail_count++;
        end
        for (int t = 0; t < test_nwords.size(); t++) begin
            run_program(t, wbase, ebase);
            wbase += test_nwords[t];
            ebase += test_nexp[t];
        end
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/rv_vectors.txt */
# each test: nwords nexp trap, then nwords program words (hex, from address 0),
# then nexp expected io_data values (hex) in order
# arithmetic and logic
23 10 0
06400093 FFD00113 002081B3 10302023 40208233 10402023 0020F2B3 10502023
0020E333 10602023 0020C3B3 10702023 00409413 10802023 00415493 10902023
40415513 10A02023 001125B3 10B02023 00113633 10C02023 0000006F
00000061 00000067 00000064 FFFFFFFD FFFFFF99 00000640 0FFFFFFF FFFFFFFF 00000001 00000000
# loads and stores at 0x200
22 7 0
20000093 FFF00113 0020A023 5A500193 00309123 08000213 004080A3 00108283
10502023 0010C303 10602023 00009383 10702023 0000D403 10802023 0020D483
10902023 0000A503 10A02023 00008583 10B02023 0000006F
FFFFFF80 00000080 FFFF80FF 000080FF 000005A5 05A580FF FFFFFFFF
# branches, taken and not taken, markers 7 and 9
41 18 0
00500093 FFD00113 00700193 00900213
00108463 10402023 10302023 00208463 10402023 10302023
00209463 10402023 10302023 00109463 10402023 10302023
00114463 10402023 10302023 0020C463 10402023 10302023
0020D463 10402023 10302023 00115463 10402023 10302023
0020E463 10402023 10302023 00116463 10402023 10302023
00117463 10402023 10302023 0020F463 10402023 10302023
0000006F
00000007 00000009 00000007 00000007 00000009 00000007 00000007 00000009 00000007
00000007 00000009 00000007 00000007 00000009 00000007 00000007 00000009 00000007
# jal and jalr link values
13 3 0
02000093 00C002EF 10002023 10002023 10502023 00008367 10002023 10002023
10602023 00C0006F 10702023 0000006F FF9FF3EF
00000008 00000018 00000034
# undefined opcode after one marker
4 1 1
05500093 10102023 00000000 10102023
00000055

/* list.f */
hdl/alu_pkg.sv
hdl/rv_pkg.sv
hdl/alu.sv
hdl/alu_dec.sv
hdl/controller_multicycle.sv
hdl/datapath.sv
hdl/rv_mem.sv
hdl/rv_core.sv
tests/tb_clock.sv
tests/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(BUILD_DIR)
